//--- apb_to_cache.sv
// apb slave front end of the cache subsystem
// checks the address, hands one request at a time to the cache
// and completes the transfer when the cache answers
`timescale 1ns/1ps
`include "cache_params.svh"

module apb_to_cache
  import cache_pkg::*;
(
  input  logic              clock_i
  ,input  logic              arst_n_i
  ,input  logic              psel_i
  ,input  logic              penable_i
  ,input  logic              pwrite_i
  ,input  logic [31:0]       paddr_i
  ,input  logic [WORD_W-1:0] pwdata_i
  ,input  logic [MASK_W-1:0] pstrb_i
  ,output logic              pready_o
  ,output logic [WORD_W-1:0] prdata_o
  ,output logic              pslverr_o

  ,output logic              req_valid_o
  ,output cache_req_s        req_o
  ,input  logic              req_ready_i

  ,input  logic              rsp_valid_i
  ,input  cache_rsp_s        rsp_i
);

  typedef enum logic [1:0] {S_IDLE, S_ISSUE, S_WAIT} state_e;

  state_e state_q;
  logic   setup;
  logic   addr_err;

  assign setup = psel_i && !penable_i;
  // beyond 4 KB or not word aligned
  assign addr_err = (|paddr_i[31:`CACHE_ADDR_W]) || (|paddr_i[1:0]);

  always_ff @(posedge clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= S_IDLE;
      pready_o    <= 1'b0;
      pslverr_o   <= 1'b0;
      req_valid_o <= 1'b0;
    end else begin
      pready_o  <= 1'b0; // single cycle pulses
      pslverr_o <= 1'b0;
      case (state_q)
        S_IDLE: begin
          if (setup) begin
            if (addr_err) begin
              pready_o  <= 1'b1; // finish in first access cycle
              pslverr_o <= 1'b1;
            end else begin
              req_valid_o <= 1'b1;
              state_q     <= S_ISSUE;
            end
          end
        end
        S_ISSUE: begin
          if (req_ready_i) begin
            req_valid_o <= 1'b0;
            state_q     <= S_WAIT;
          end
        end
        S_WAIT: begin
          if (rsp_valid_i) begin
            pready_o <= 1'b1;
            state_q  <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock_i) begin
    if (state_q == S_IDLE && setup) begin
      req_o.write_not_read <= pwrite_i;
      req_o.addr.word      <= paddr_i[`CACHE_ADDR_W-1:2];
      req_o.wdata          <= pwdata_i;
      req_o.mask           <= pwrite_i ? pstrb_i : '0;
    end
    if (state_q == S_WAIT && rsp_valid_i && !req_o.write_not_read) begin
      prdata_o <= rsp_i.rdata;
    end
  end

endmodule

//--- cache_core.sv
// blocking two-way write-back cache
// hits answer two cycles after accept; a miss evicts a dirty victim,
// fills the line through the dma stage and then replays as a hit
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_core
  import cache_pkg::*;
(
  input  logic                clock_i
  ,input  logic                arst_n_i

  ,input  logic                req_valid_i
  ,input  cache_req_s          req_i
  ,output logic                req_ready_o

  ,output logic                rsp_valid_o
  ,output cache_rsp_s          rsp_o

  ,output logic                dma_valid_o
  ,output dma_req_s            dma_req_o
  ,input  logic                dma_ready_i
  ,input  logic                dma_done_i

  ,input  logic                fill_valid_i
  ,input  logic [OFFSET_W-1:0] fill_idx_i
  ,input  logic [WORD_W-1:0]   fill_data_i

  ,input  logic [OFFSET_W-1:0] evict_idx_i
  ,output logic [WORD_W-1:0]   evict_data_o
);

  typedef enum logic [2:0] {S_IDLE, S_TAG, S_CMP, S_EVICT, S_FILL} state_e;

  state_e state_q;

  logic [WORD_W-1:0]      data_mem [`CACHE_WAYS][`CACHE_SETS][`CACHE_BLOCK_WORDS];
  logic [TAG_W-1:0]       tag_mem  [`CACHE_WAYS][`CACHE_SETS];
  logic [`CACHE_WAYS-1:0] valid_q  [`CACHE_SETS];
  logic [`CACHE_WAYS-1:0] dirty_q  [`CACHE_SETS];
  logic [WAY_W-1:0]       lru_q    [`CACHE_SETS]; // way to replace next

  cache_req_s             req_q;
  logic [TAG_W-1:0]       tag_rd [`CACHE_WAYS];
  logic [`CACHE_WAYS-1:0] valid_rd;
  logic [`CACHE_WAYS-1:0] dirty_rd;
  logic [WAY_W-1:0]       lru_rd;
  logic [WAY_W-1:0]       victim_q;

  logic [INDEX_W-1:0]     idx;
  logic [OFFSET_W-1:0]    off;
  logic                   hit;
  logic [WAY_W-1:0]       hit_way;

  assign idx = req_q.addr.f.index;
  assign off = req_q.addr.f.offset;
  assign req_ready_o = (state_q == S_IDLE);

  always_comb begin
    hit     = 1'b0;
    hit_way = '0;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (valid_rd[w] && tag_rd[w] == req_q.addr.f.tag) begin
        hit     = 1'b1;
        hit_way = WAY_W'(w);
      end
    end
  end

  // evict writes back the victim line, fill fetches the requested one
  assign dma_req_o.write_not_read = (state_q == S_EVICT);
  assign dma_req_o.block = (state_q == S_EVICT) ? {tag_mem[victim_q][idx], idx}
                                                : {req_q.addr.f.tag, idx};

  assign evict_data_o = data_mem[victim_q][idx][evict_idx_i];

  always_ff @(posedge clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= S_IDLE;
      rsp_valid_o <= 1'b0;
      dma_valid_o <= 1'b0;
      valid_q     <= '{default: '0};
      dirty_q     <= '{default: '0};
      lru_q       <= '{default: '0};
    end else begin
      rsp_valid_o <= 1'b0;
      if (dma_valid_o && dma_ready_i) begin
        dma_valid_o <= 1'b0;
      end
      case (state_q)
        S_IDLE: begin
          if (req_valid_i) begin
            state_q <= S_TAG;
          end
        end
        S_TAG: state_q <= S_CMP;
        S_CMP: begin
          if (hit) begin
            rsp_valid_o  <= 1'b1;
            lru_q[idx]   <= ~hit_way; // other way becomes lru
            if (req_q.write_not_read) begin
              dirty_q[idx][hit_way] <= 1'b1;
            end
            state_q <= S_IDLE;
          end else if (valid_rd[lru_rd] && dirty_rd[lru_rd]) begin
            dma_valid_o <= 1'b1;
            state_q     <= S_EVICT;
          end else begin
            dma_valid_o <= 1'b1;
            state_q     <= S_FILL;
          end
        end
        S_EVICT: begin
          if (dma_done_i) begin
            dirty_q[idx][victim_q] <= 1'b0;
            dma_valid_o            <= 1'b1; // fill follows the write-back
            state_q                <= S_FILL;
          end
        end
        S_FILL: begin
          if (dma_done_i) begin
            valid_q[idx][victim_q] <= 1'b1;
            dirty_q[idx][victim_q] <= 1'b0;
            state_q                <= S_TAG; // replay, now a hit
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock_i) begin
    if (state_q == S_IDLE && req_valid_i) begin
      req_q <= req_i;
    end
    if (state_q == S_TAG) begin
      for (int w = 0; w < `CACHE_WAYS; w++) begin
        tag_rd[w] <= tag_mem[w][idx];
      end
      valid_rd <= valid_q[idx];
      dirty_rd <= dirty_q[idx];
      lru_rd   <= lru_q[idx];
    end
    if (state_q == S_CMP && !hit) begin
      victim_q <= lru_rd;
    end
    if (state_q == S_CMP && hit) begin
      rsp_o.rdata <= data_mem[hit_way][idx][off];
      if (req_q.write_not_read) begin
        for (int b = 0; b < MASK_W; b++) begin
          if (req_q.mask[b]) begin
            data_mem[hit_way][idx][off][8*b +: 8] <= req_q.wdata[8*b +: 8];
          end
        end
      end
    end
    if (state_q == S_FILL && fill_valid_i) begin
      data_mem[victim_q][idx][fill_idx_i] <= fill_data_i;
    end
    if (state_q == S_FILL && dma_done_i) begin
      tag_mem[victim_q][idx] <= req_q.addr.f.tag;
    end
  end

endmodule

//--- cache_dma.sv
// block mover between the cache and the dram model
// splits a line fill or write-back into word commands and
// streams returning read words into the cache line
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_dma
  import cache_pkg::*;
(
  input  logic                clock_i
  ,input  logic                arst_n_i

  ,input  logic                dma_valid_i
  ,input  dma_req_s            dma_req_i
  ,output logic                dma_ready_o
  ,output logic                dma_done_o

  ,output logic                fill_valid_o
  ,output logic [OFFSET_W-1:0] fill_idx_o
  ,output logic [WORD_W-1:0]   fill_data_o

  ,output logic [OFFSET_W-1:0] evict_idx_o
  ,input  logic [WORD_W-1:0]   evict_data_i

  ,output logic                cmd_valid_o
  ,output dram_cmd_s           cmd_o
  ,input  logic                cmd_ready_i

  ,input  logic                rd_valid_i
  ,input  logic [WORD_W-1:0]   rd_data_i
);

  typedef enum logic [1:0] {S_IDLE, S_WR, S_RD} state_e;

  localparam logic [OFFSET_W:0] LAST_CMD = (OFFSET_W+1)'(`CACHE_BLOCK_WORDS - 1);
  localparam logic [OFFSET_W-1:0] LAST_RD = OFFSET_W'(`CACHE_BLOCK_WORDS - 1);

  state_e              state_q;
  dma_req_s            req_q;
  logic [OFFSET_W:0]   cmd_cnt_q; // one extra bit, stops read issue
  logic [OFFSET_W-1:0] rd_cnt_q;
  logic                cmd_fire;
  logic                last_rd;

  assign dma_ready_o = (state_q == S_IDLE);
  assign cmd_valid_o = (state_q != S_IDLE) && (cmd_cnt_q < `CACHE_BLOCK_WORDS);
  assign cmd_fire    = cmd_valid_o && cmd_ready_i;
  assign last_rd     = rd_valid_i && (rd_cnt_q == LAST_RD);

  assign cmd_o.write_not_read = (state_q == S_WR);
  assign cmd_o.addr           = {req_q.block, cmd_cnt_q[OFFSET_W-1:0]};
  assign cmd_o.wdata          = evict_data_i;
  assign evict_idx_o          = cmd_cnt_q[OFFSET_W-1:0];

  assign fill_valid_o = (state_q == S_RD) && rd_valid_i;
  assign fill_idx_o   = rd_cnt_q;
  assign fill_data_o  = rd_data_i;

  assign dma_done_o = (state_q == S_WR && cmd_fire && cmd_cnt_q == LAST_CMD)
                   || (state_q == S_RD && last_rd);

  always_ff @(posedge clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= S_IDLE;
      cmd_cnt_q <= '0;
      rd_cnt_q  <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (dma_valid_i) begin
            state_q   <= dma_req_i.write_not_read ? S_WR : S_RD;
            cmd_cnt_q <= '0;
            rd_cnt_q  <= '0;
          end
        end
        S_WR: begin
          if (cmd_fire) begin
            cmd_cnt_q <= cmd_cnt_q + 1'b1;
            if (cmd_cnt_q == LAST_CMD) begin
              state_q <= S_IDLE;
            end
          end
        end
        S_RD: begin
          if (cmd_fire) begin
            cmd_cnt_q <= cmd_cnt_q + 1'b1;
          end
          if (rd_valid_i) begin
            rd_cnt_q <= rd_cnt_q + 1'b1; // read data is never stalled
          end
          if (last_rd) begin
            state_q <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock_i) begin
    if (dma_ready_o && dma_valid_i) begin
      req_q <= dma_req_i;
    end
  end

endmodule

//--- cache_params.svh
// sizing for the apb cache subsystem
// included by the package and by any module that sizes an array
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// byte address space seen on apb, 4 KB
`define CACHE_ADDR_W 12

// cache geometry
`define CACHE_SETS 16
`define CACHE_WAYS 2
`define CACHE_BLOCK_WORDS 4 // 32-bit words per line

// backing store
`define DRAM_WORDS 1024
`define DRAM_LATENCY 3 // cycles from read accept to data

// word n of dram comes out of reset as n ^ this
`define DRAM_INIT_XOR 32'hA5A50000

`endif

//--- cache_pkg.sv
// types shared by the apb adapter, cache, dma and dram model
// modules take these with a wildcard import
`include "cache_params.svh"

package cache_pkg;

  localparam int WORD_W = 32;
  localparam int MASK_W = WORD_W / 8;
  localparam int WORD_ADDR_W = `CACHE_ADDR_W - 2;
  localparam int OFFSET_W = $clog2(`CACHE_BLOCK_WORDS);
  localparam int INDEX_W = $clog2(`CACHE_SETS);
  localparam int TAG_W = WORD_ADDR_W - INDEX_W - OFFSET_W;
  localparam int BLOCK_ADDR_W = TAG_W + INDEX_W; // tag plus index
  localparam int WAY_W = $clog2(`CACHE_WAYS);

  typedef struct packed {
    logic [TAG_W-1:0]    tag;
    logic [INDEX_W-1:0]  index;
    logic [OFFSET_W-1:0] offset;
  } cache_addr_fields_s;

  // word address, flat or split into cache fields
  typedef union packed {
    logic [WORD_ADDR_W-1:0] word;
    cache_addr_fields_s     f;
  } cache_addr_u;

  typedef struct packed {
    logic              write_not_read;
    cache_addr_u       addr;
    logic [WORD_W-1:0] wdata;
    logic [MASK_W-1:0] mask;
  } cache_req_s;

  typedef struct packed {
    logic [WORD_W-1:0] rdata;
  } cache_rsp_s;

  typedef struct packed {
    logic                    write_not_read;
    logic [BLOCK_ADDR_W-1:0] block;
  } dma_req_s;

  typedef struct packed {
    logic                   write_not_read;
    logic [WORD_ADDR_W-1:0] addr;
    logic [WORD_W-1:0]      wdata;
  } dram_cmd_s;

endpackage

//--- cache_top.sv
// apb-attached cache subsystem
// apb slave -> cache -> dma -> dram model, one access in flight
`timescale 1ns/1ps

module cache_top
  import cache_pkg::*;
(
  input  logic              clock_i
  ,input  logic              arst_n_i
  ,input  logic              psel_i
  ,input  logic              penable_i
  ,input  logic              pwrite_i
  ,input  logic [31:0]       paddr_i
  ,input  logic [WORD_W-1:0] pwdata_i
  ,input  logic [MASK_W-1:0] pstrb_i
  ,output logic              pready_o
  ,output logic [WORD_W-1:0] prdata_o
  ,output logic              pslverr_o
);

  logic                req_valid;
  logic                req_ready;
  cache_req_s          cache_req;
  logic                rsp_valid;
  cache_rsp_s          cache_rsp;

  logic                dma_valid;
  logic                dma_ready;
  logic                dma_done;
  dma_req_s            dma_req;
  logic                fill_valid;
  logic [OFFSET_W-1:0] fill_idx;
  logic [WORD_W-1:0]   fill_data;
  logic [OFFSET_W-1:0] evict_idx;
  logic [WORD_W-1:0]   evict_data;

  logic                cmd_valid;
  logic                cmd_ready;
  dram_cmd_s           dram_cmd;
  logic                rd_valid;
  logic [WORD_W-1:0]   rd_data;

  apb_to_cache apb (
    .clock_i(clock_i)
    ,.arst_n_i(arst_n_i)
    ,.psel_i(psel_i)
    ,.penable_i(penable_i)
    ,.pwrite_i(pwrite_i)
    ,.paddr_i(paddr_i)
    ,.pwdata_i(pwdata_i)
    ,.pstrb_i(pstrb_i)
    ,.pready_o(pready_o)
    ,.prdata_o(prdata_o)
    ,.pslverr_o(pslverr_o)
    ,.req_valid_o(req_valid)
    ,.req_o(cache_req)
    ,.req_ready_i(req_ready)
    ,.rsp_valid_i(rsp_valid)
    ,.rsp_i(cache_rsp)
  );

  cache_core cache (
    .clock_i(clock_i)
    ,.arst_n_i(arst_n_i)
    ,.req_valid_i(req_valid)
    ,.req_i(cache_req)
    ,.req_ready_o(req_ready)
    ,.rsp_valid_o(rsp_valid)
    ,.rsp_o(cache_rsp)
    ,.dma_valid_o(dma_valid)
    ,.dma_req_o(dma_req)
    ,.dma_ready_i(dma_ready)
    ,.dma_done_i(dma_done)
    ,.fill_valid_i(fill_valid)
    ,.fill_idx_i(fill_idx)
    ,.fill_data_i(fill_data)
    ,.evict_idx_i(evict_idx)
    ,.evict_data_o(evict_data)
  );

  cache_dma dma (
    .clock_i(clock_i)
    ,.arst_n_i(arst_n_i)
    ,.dma_valid_i(dma_valid)
    ,.dma_req_i(dma_req)
    ,.dma_ready_o(dma_ready)
    ,.dma_done_o(dma_done)
    ,.fill_valid_o(fill_valid)
    ,.fill_idx_o(fill_idx)
    ,.fill_data_o(fill_data)
    ,.evict_idx_o(evict_idx)
    ,.evict_data_i(evict_data)
    ,.cmd_valid_o(cmd_valid)
    ,.cmd_o(dram_cmd)
    ,.cmd_ready_i(cmd_ready)
    ,.rd_valid_i(rd_valid)
    ,.rd_data_i(rd_data)
  );

  mock_dram dram (
    .clock_i(clock_i)
    ,.arst_n_i(arst_n_i)
    ,.cmd_valid_i(cmd_valid)
    ,.cmd_i(dram_cmd)
    ,.cmd_ready_o(cmd_ready)
    ,.rd_valid_o(rd_valid)
    ,.rd_data_o(rd_data)
  );

endmodule

//--- files.f
+incdir+.
cache_pkg.sv
apb_to_cache.sv
cache_core.sv
cache_dma.sv
mock_dram.sv
cache_top.sv
tb_cache_top.sv

//--- mock_dram.sv
// word-wide dram model behind the dma stage
// fixed read latency, always ready, pattern loaded on reset
`timescale 1ns/1ps
`include "cache_params.svh"

module mock_dram
  import cache_pkg::*;
(
  input  logic              clock_i
  ,input  logic              arst_n_i

  ,input  logic              cmd_valid_i
  ,input  dram_cmd_s         cmd_i
  ,output logic              cmd_ready_o

  ,output logic              rd_valid_o
  ,output logic [WORD_W-1:0] rd_data_o
);

  logic [WORD_W-1:0]        mem [`DRAM_WORDS];
  logic [`DRAM_LATENCY-1:0] rd_v_q;
  logic [WORD_W-1:0]        rd_d_q [`DRAM_LATENCY];
  logic                     rd_accept;
  logic                     wr_accept;

  assign cmd_ready_o = 1'b1;
  assign rd_accept   = cmd_valid_i && cmd_ready_o && !cmd_i.write_not_read;
  assign wr_accept   = cmd_valid_i && cmd_ready_o && cmd_i.write_not_read;

  always_ff @(posedge clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < `DRAM_WORDS; i++) begin
        mem[i] <= WORD_W'(i) ^ `DRAM_INIT_XOR;
      end
    end else if (wr_accept) begin
      mem[cmd_i.addr] <= cmd_i.wdata;
    end
  end

  // latency pipe, up to DRAM_LATENCY reads in flight
  always_ff @(posedge clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_v_q <= '0;
    end else begin
      rd_v_q <= {rd_v_q[`DRAM_LATENCY-2:0], rd_accept};
    end
  end

  always_ff @(posedge clock_i) begin
    rd_d_q[0] <= mem[cmd_i.addr];
    for (int s = 1; s < `DRAM_LATENCY; s++) begin
      rd_d_q[s] <= rd_d_q[s-1];
    end
  end

  assign rd_valid_o = rd_v_q[`DRAM_LATENCY-1];
  assign rd_data_o  = rd_d_q[`DRAM_LATENCY-1];

endmodule

//--- run.sh
#!/usr/bin/env bash
# builds the cache subsystem testbench with verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_cache_top -Mdir "$OBJ" -f files.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ/Vtb_cache_top" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST PASS" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- tb_cache_top.sv
// testbench for the apb cache subsystem
// runs apb reads and writes against a model of dram contents and
// checks read data, error responses and the apb handshake
`timescale 1ns/1ps
`include "cache_params.svh"

module tb_cache_top;

  localparam int CLK_PERIOD = 4;
  localparam int RESET_OPS  = 8;
  localparam int DIRECT_OPS = 10;
  localparam int EVICT_OPS  = 12;
  localparam int RANDOM_OPS = 200;
  localparam int ERROR_OPS  = 8;
  localparam int NUM_OPS    = RESET_OPS + DIRECT_OPS + EVICT_OPS + RANDOM_OPS + ERROR_OPS;
  localparam int MAX_WAIT   = 64; // cycles one access phase may take
  localparam int TIMEOUT_NS = NUM_OPS * MAX_WAIT * CLK_PERIOD + 1000;

  logic        clk;
  logic        arst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] paddr;
  logic [31:0] pwdata;
  logic [3:0]  pstrb;
  logic        pready;
  logic [31:0] prdata;
  logic        pslverr;

  logic [31:0] model [`DRAM_WORDS];
  int          data_errors;
  int          protocol_errors;
  int          wait_cycles;

  cache_top dut (
    .clock_i(clk)
    ,.arst_n_i(arst_n)
    ,.psel_i(psel)
    ,.penable_i(penable)
    ,.pwrite_i(pwrite)
    ,.paddr_i(paddr)
    ,.pwdata_i(pwdata)
    ,.pstrb_i(pstrb)
    ,.pready_o(pready)
    ,.prdata_o(prdata)
    ,.pslverr_o(pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // pready only inside an access phase
  pready_in_access: assert property (@(posedge clk) disable iff (!arst_n)
      pready |-> (psel && penable))
    else begin
      protocol_errors++;
      $display("CHECK FAILED pready_o outside access phase: psel_i 0x%0h penable_i 0x%0h",
               psel, penable);
    end

  // errors only with pready
  slverr_with_ready: assert property (@(posedge clk) disable iff (!arst_n)
      pslverr |-> pready)
    else begin
      protocol_errors++;
      $display("CHECK FAILED pslverr_o 0x%0h while pready_o 0x%0h", pslverr, pready);
    end

  // access phase must end within MAX_WAIT cycles
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wait_cycles <= 0;
    end else begin
      assert (wait_cycles < MAX_WAIT) else begin
        protocol_errors++;
        $display("pready_o did not rise within %0d cycles of the access phase", MAX_WAIT);
      end
      if (psel && penable && !pready) begin
        wait_cycles <= wait_cycles + 1;
      end else begin
        wait_cycles <= 0;
      end
    end
  end

  function automatic void model_write(input logic [9:0] widx, input logic [31:0] data,
                                      input logic [3:0] strb);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        model[widx][8*b +: 8] = data[8*b +: 8];
      end
    end
  endfunction

  task automatic expect_low(input string name, input logic value);
    assert (value == 1'b0) else begin
      data_errors++;
      $display("CHECK FAILED %s after reset: got 0x%0h expected 0x0", name, value);
    end
  endtask

  // called and returns 0.5 ns after a rising edge
  task automatic apb_transfer(input logic write, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic [3:0] strb,
                              output logic [31:0] rdata, output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    pstrb   = write ? strb : 4'h0; // no strobes on reads
    @(posedge clk);
    #0.5;
    penable = 1'b1;
    while (!pready) begin
      @(posedge clk);
      #0.5;
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #0.5;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
    logic [31:0] rdata;
    logic        err;
    apb_transfer(1'b1, addr, data, strb, rdata, err);
    assert (err == 1'b0) else begin
      data_errors++;
      $display("CHECK FAILED pslverr_o write 0x%08h: got 0x%0h expected 0x0", addr, err);
    end
    model_write(addr[`CACHE_ADDR_W-1:2], data, strb);
  endtask

  task automatic read_check(input logic [31:0] addr);
    logic [31:0] rdata;
    logic        err;
    logic [31:0] exp;
    exp = model[addr[`CACHE_ADDR_W-1:2]];
    apb_transfer(1'b0, addr, 32'h0, 4'h0, rdata, err);
    assert (err == 1'b0) else begin
      data_errors++;
      $display("CHECK FAILED pslverr_o read 0x%08h: got 0x%0h expected 0x0", addr, err);
    end
    assert (rdata == exp) else begin
      data_errors++;
      $display("CHECK FAILED prdata_o read 0x%08h: got 0x%08h expected 0x%08h",
               addr, rdata, exp);
    end
  endtask

  task automatic reject_check(input logic write, input logic [31:0] addr);
    logic [31:0] rdata;
    logic        err;
    apb_transfer(write, addr, 32'hDEAD_BEEF, 4'hF, rdata, err);
    assert (err == 1'b1) else begin
      data_errors++;
      $display("CHECK FAILED pslverr_o bad address 0x%08h: got 0x%0h expected 0x1", addr, err);
    end
  endtask

  initial begin
    logic [9:0]  widx;
    logic [31:0] addr;
    void'($urandom(16798));
    data_errors     = 0;
    protocol_errors = 0;
    arst_n  = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = 32'h0;
    pwdata  = 32'h0;
    pstrb   = 4'h0;
    for (int i = 0; i < `DRAM_WORDS; i++) begin
      model[i] = 32'(i) ^ `DRAM_INIT_XOR;
    end
    repeat (3) @(posedge clk);
    #0.5;
    arst_n = 1'b1;

    expect_low("pready_o", pready);
    expect_low("pslverr_o", pslverr);
    expect_low("req_valid", dut.apb.req_valid_o);
    expect_low("rsp_valid", dut.cache.rsp_valid_o);
    expect_low("dma_valid", dut.cache.dma_valid_o);
    expect_low("cmd_valid", dut.dma.cmd_valid_o);
    expect_low("rd_valid", dut.dram.rd_valid_o);

    // reset contents
    read_check(32'h000);
    read_check(32'h004);
    read_check(32'h0FC);
    read_check(32'h100);
    read_check(32'h550);
    read_check(32'hFFC);
    read_check(32'h7A8);
    read_check(32'h3C0);

    // full and partial writes
    write_word(32'h200, 32'h1234_5678, 4'hF);
    read_check(32'h200);
    write_word(32'h200, 32'hAAAA_AAAA, 4'b0001);
    read_check(32'h200);
    write_word(32'h200, 32'h5555_5555, 4'b0110);
    read_check(32'h200);
    write_word(32'h204, 32'hCC00_0000, 4'b1000);
    read_check(32'h204);
    write_word(32'h9A4, 32'h0F0F_0F0F, 4'b0101); // partial write on a miss
    read_check(32'h9A4);

    // third tag in set 5 evicts a dirty line
    for (int t = 0; t < 3; t++) begin
      write_word({20'h0, 4'(4'hA + t), 4'h5, 4'h0}, 32'hB000_0000 + 32'(t), 4'hF);
      write_word({20'h0, 4'(4'hA + t), 4'h5, 4'hC}, 32'hC000_0000 + 32'(t), 4'hF);
    end
    for (int t = 0; t < 3; t++) begin
      read_check({20'h0, 4'(4'hA + t), 4'h5, 4'h0});
      read_check({20'h0, 4'(4'hA + t), 4'h5, 4'hC});
    end

    for (int i = 0; i < RANDOM_OPS; i++) begin
      widx = 10'($urandom_range(`DRAM_WORDS - 1, 0));
      addr = {20'h0, widx, 2'b00};
      if ($urandom_range(1, 0) == 1) begin
        write_word(addr, $urandom(), 4'($urandom()));
      end else begin
        read_check(addr);
      end
    end

    // rejected addresses leave memory alone
    reject_check(1'b1, 32'h0000_1000); // would alias word 0
    reject_check(1'b0, 32'h0000_1FFC);
    reject_check(1'b1, 32'h8000_0100);
    reject_check(1'b1, 32'h0000_0102);
    reject_check(1'b0, 32'h0000_03C1);
    read_check(32'h000);
    read_check(32'h100);
    read_check(32'h3C0);

    repeat (2) @(posedge clk);
    $display("errors: data %0d, protocol %0d", data_errors, protocol_errors);
    if (data_errors == 0 && protocol_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout, run did not finish within %0d ns", TIMEOUT_NS);
    $display("TEST FAIL");
    $finish;
  end

endmodule
